// ==== battle_pkg.sv ====
package battle_pkg;

    //////////////////////////////////////////////////////////////////////
    // serial line timing
    //////////////////////////////////////////////////////////////////////

    // kept short so a frame simulates quickly
    localparam int CLKS_PER_BIT   = 16;
    localparam int UART_DATA_BITS = 8;
    localparam int BAUD_W         = $clog2(CLKS_PER_BIT);

    //////////////////////////////////////////////////////////////////////
    // game rules
    //////////////////////////////////////////////////////////////////////

    localparam logic [15:0] MONSTER_MAX_HP = 16'd200;
    localparam logic [15:0] PLAYER_DAMAGE  = 16'd50;

    // turn lengths in clock cycles
    localparam int ATTACK_WINDOW_CYCLES = 4000;
    localparam int MONSTER_TURN_CYCLES  = 3000;
    localparam int TIMER_W              = 13;

    // ascii codes of the keys the game reacts to
    localparam logic [7:0] BYTE_ENTER = 8'h0d;
    localparam logic [7:0] BYTE_SPACE = 8'h20;
    localparam logic [7:0] BYTE_A     = 8'h61;
    localparam logic [7:0] BYTE_D     = 8'h64;

    typedef enum logic [2:0] {
        KEY_NONE,
        KEY_ENTER,
        KEY_SPACE,
        KEY_LEFT,
        KEY_RIGHT
    } key_code_t;

    typedef enum logic [1:0] {
        ST_HOME,
        ST_MENU,
        ST_PLAYER_ATTACK,
        ST_MONSTER_TURN
    } battle_state_t;

    // left to right as shown on screen
    typedef enum logic [1:0] {
        MENU_FIGHT,
        MENU_ACT,
        MENU_ITEM,
        MENU_MERCY
    } menu_choice_t;

endpackage

// ==== uart_rx.sv ====
`timescale 1ns/1ps

module uart_rx import battle_pkg::*; (
    input  logic                      clk,
    input  logic                      cursor_position_rst,
    input  logic                      i_rx,
    output logic [UART_DATA_BITS-1:0] o_rx_byte,
    output logic                      o_rx_valid
);

    typedef enum logic [1:0] {
        RX_IDLE,
        RX_START,
        RX_DATA,
        RX_STOP
    } rx_state_t;

    rx_state_t         rx_state;
    logic [1:0]        rx_sync;
    logic [BAUD_W-1:0] baud_cnt;
    logic [2:0]        bit_idx;
    logic              baud_half;
    logic              baud_full;

    assign baud_half = (baud_cnt == BAUD_W'(CLKS_PER_BIT / 2 - 1));
    assign baud_full = (baud_cnt == BAUD_W'(CLKS_PER_BIT - 1));

    // two-flop synchronizer that resets to the idle high line
    always_ff @(posedge clk) begin
        if (cursor_position_rst) begin
            rx_sync <= 2'b11;
        end else begin
            rx_sync <= {rx_sync[0], i_rx};
        end
    end

    //////////////////////////////////////////////////////////////////////
    // frame FSM
    //////////////////////////////////////////////////////////////////////

    always_ff @(posedge clk) begin
        if (cursor_position_rst) begin
            rx_state   <= RX_IDLE;
            baud_cnt   <= '0;
            bit_idx    <= '0;
            o_rx_valid <= 1'b0;
        end else begin
            o_rx_valid <= 1'b0;
            case (rx_state)
                RX_IDLE: begin
                    bit_idx <= '0;
                    if (!rx_sync[1]) begin
                        // credit the cycles the edge spent in the synchronizer
                        baud_cnt <= BAUD_W'($bits(rx_sync));
                        rx_state <= RX_START;
                    end
                end
                RX_START: begin
                    if (baud_half) begin
                        baud_cnt <= '0;
                        // line back high means a glitch, not a start bit
                        rx_state <= rx_sync[1] ? RX_IDLE : RX_DATA;
                    end else begin
                        baud_cnt <= baud_cnt + 1'b1;
                    end
                end
                RX_DATA: begin
                    if (baud_full) begin
                        baud_cnt <= '0;
                        bit_idx  <= bit_idx + 1'b1;
                        if (bit_idx == 3'(UART_DATA_BITS - 1)) begin
                            rx_state <= RX_STOP;
                        end
                    end else begin
                        baud_cnt <= baud_cnt + 1'b1;
                    end
                end
                RX_STOP: begin
                    if (baud_full) begin
                        baud_cnt   <= '0;
                        // framing error drops the byte
                        o_rx_valid <= rx_sync[1];
                        rx_state   <= RX_IDLE;
                    end else begin
                        baud_cnt <= baud_cnt + 1'b1;
                    end
                end
            endcase
        end
    end

    // lsb arrives first
    always_ff @(posedge clk) begin
        if (rx_state == RX_DATA && baud_full) begin
            o_rx_byte <= {rx_sync[1], o_rx_byte[UART_DATA_BITS-1:1]};
        end
    end

endmodule

// ==== uart_tx.sv ====
`timescale 1ns/1ps

module uart_tx import battle_pkg::*; (
    input  logic                      clk,
    input  logic                      cursor_position_rst,
    input  logic                      i_start,
    input  logic [UART_DATA_BITS-1:0] i_byte,
    output logic                      o_tx,
    output logic                      o_busy
);

    // stop bit, data, start bit from msb down to lsb
    logic [UART_DATA_BITS+1:0] frame;
    logic [BAUD_W-1:0]         baud_cnt;
    logic [3:0]                bit_cnt;
    logic                      baud_done;

    assign baud_done = (baud_cnt == BAUD_W'(CLKS_PER_BIT - 1));

    // line follows the low end of the frame, idle ones shift in behind it
    assign o_tx = frame[0];

    always_ff @(posedge clk) begin
        if (cursor_position_rst) begin
            frame    <= '1;
            baud_cnt <= '0;
            bit_cnt  <= '0;
            o_busy   <= 1'b0;
        end else if (!o_busy) begin
            // a start while busy never reaches this branch
            if (i_start) begin
                frame    <= {1'b1, i_byte, 1'b0};
                baud_cnt <= '0;
                bit_cnt  <= '0;
                o_busy   <= 1'b1;
            end
        end else if (baud_done) begin
            baud_cnt <= '0;
            frame    <= {1'b1, frame[UART_DATA_BITS+1:1]};
            if (bit_cnt == 4'(UART_DATA_BITS + 1)) begin
                // end of stop bit
                bit_cnt <= '0;
                o_busy  <= 1'b0;
            end else begin
                bit_cnt <= bit_cnt + 1'b1;
            end
        end else begin
            baud_cnt <= baud_cnt + 1'b1;
        end
    end

endmodule

// ==== key_decoder.sv ====
`timescale 1ns/1ps

module key_decoder import battle_pkg::*; (
    input  logic       clk,
    input  logic       cursor_position_rst,
    input  logic [7:0] i_rx_byte,
    input  logic       i_rx_valid,
    input  logic       i_tx_busy,
    output key_code_t  o_key,
    output logic       o_key_valid,
    output logic [7:0] o_echo_byte,
    output logic       o_echo_start
);

    key_code_t key_next;
    logic      key_hit;

    always_comb begin
        case (i_rx_byte)
            BYTE_ENTER: key_next = KEY_ENTER;
            BYTE_SPACE: key_next = KEY_SPACE;
            BYTE_A:     key_next = KEY_LEFT;
            BYTE_D:     key_next = KEY_RIGHT;
            default:    key_next = KEY_NONE;
        endcase
    end

    assign key_hit = i_rx_valid && (key_next != KEY_NONE);

    always_ff @(posedge clk) begin
        if (cursor_position_rst) begin
            o_key_valid  <= 1'b0;
            o_echo_start <= 1'b0;
        end else begin
            o_key_valid  <= key_hit;
            // busy transmitter means this echo is lost, the key still counts
            o_echo_start <= key_hit && !i_tx_busy;
        end
    end

    always_ff @(posedge clk) begin
        if (key_hit) begin
            o_key       <= key_next;
            o_echo_byte <= i_rx_byte;
        end
    end

endmodule

// ==== menu_cursor.sv ====
`timescale 1ns/1ps

module menu_cursor import battle_pkg::*; (
    input  logic         clk,
    input  logic         cursor_position_rst,
    input  logic         i_clear,
    input  key_code_t    i_key,
    input  logic         i_key_valid,
    output menu_choice_t o_cursor
);

    // saturates at both ends, moves in every game state
    always_ff @(posedge clk) begin
        if (cursor_position_rst) begin
            o_cursor <= MENU_FIGHT;
        end else if (i_clear) begin
            o_cursor <= MENU_FIGHT;
        end else if (i_key_valid) begin
            if (i_key == KEY_LEFT && o_cursor != MENU_FIGHT) begin
                o_cursor <= menu_choice_t'(o_cursor - 2'd1);
            end else if (i_key == KEY_RIGHT && o_cursor != MENU_MERCY) begin
                o_cursor <= menu_choice_t'(o_cursor + 2'd1);
            end
        end
    end

endmodule

// ==== battle_fsm.sv ====
`timescale 1ns/1ps

module battle_fsm import battle_pkg::*; (
    input  logic          clk,
    input  logic          cursor_position_rst,
    input  key_code_t     i_key,
    input  logic          i_key_valid,
    input  menu_choice_t  i_cursor,
    output battle_state_t o_state,
    output logic [15:0]   o_monster_hp,
    output logic          o_cursor_clear
);

    // counts only in the two timed states, held at zero elsewhere
    logic [TIMER_W-1:0] turn_timer;
    logic               enter_key;
    logic               space_key;
    logic               attack_timeout;
    logic               turn_done;

    assign enter_key = i_key_valid && (i_key == KEY_ENTER);
    assign space_key = i_key_valid && (i_key == KEY_SPACE);

    // timer reads N-1 on the Nth edge after entering the state
    assign attack_timeout = (turn_timer == TIMER_W'(ATTACK_WINDOW_CYCLES - 1));
    assign turn_done      = (turn_timer == TIMER_W'(MONSTER_TURN_CYCLES - 1));

    // cursor goes back to FIGHT on the same edge the menu opens
    assign o_cursor_clear = ((o_state == ST_HOME) && enter_key) ||
                            ((o_state == ST_MONSTER_TURN) && turn_done);

    //////////////////////////////////////////////////////////////////////
    // game FSM
    //////////////////////////////////////////////////////////////////////

    always_ff @(posedge clk) begin
        if (cursor_position_rst) begin
            o_state      <= ST_HOME;
            o_monster_hp <= MONSTER_MAX_HP;
            turn_timer   <= '0;
        end else begin
            case (o_state)
                ST_HOME: begin
                    turn_timer <= '0;
                    if (enter_key) begin
                        o_state <= ST_MENU;
                    end
                end

                ST_MENU: begin
                    turn_timer <= '0;
                    if (enter_key) begin
                        if (i_cursor == MENU_FIGHT) begin
                            o_state <= ST_PLAYER_ATTACK;
                        end else if (i_cursor == MENU_MERCY) begin
                            // spare the monster and start over
                            o_state      <= ST_HOME;
                            o_monster_hp <= MONSTER_MAX_HP;
                        end
                        // ACT and ITEM do nothing yet
                    end
                end

                ST_PLAYER_ATTACK: begin
                    if (space_key) begin
                        turn_timer <= '0;
                        if (o_monster_hp <= PLAYER_DAMAGE) begin
                            // monster defeated
                            o_state      <= ST_HOME;
                            o_monster_hp <= MONSTER_MAX_HP;
                        end else begin
                            o_state      <= ST_MONSTER_TURN;
                            o_monster_hp <= o_monster_hp - PLAYER_DAMAGE;
                        end
                    end else if (attack_timeout) begin
                        // missed the window
                        turn_timer <= '0;
                        o_state    <= ST_MONSTER_TURN;
                    end else begin
                        turn_timer <= turn_timer + 1'b1;
                    end
                end

                ST_MONSTER_TURN: begin
                    // keys are ignored while the monster acts
                    if (turn_done) begin
                        turn_timer <= '0;
                        o_state    <= ST_MENU;
                    end else begin
                        turn_timer <= turn_timer + 1'b1;
                    end
                end
            endcase
        end
    end

endmodule

// ==== battle_top.sv ====
`timescale 1ns/1ps

module battle_top import battle_pkg::*; (
    input  logic          clk,
    input  logic          cursor_position_rst,
    input  logic          i_rx,
    output logic          o_tx,
    output battle_state_t o_state,
    output menu_choice_t  o_cursor,
    output logic [15:0]   o_monster_hp
);

    logic [7:0] rx_byte;
    logic       rx_valid;
    key_code_t  key;
    logic       key_valid;
    logic [7:0] echo_byte;
    logic       echo_start;
    logic       tx_busy;
    logic       cursor_clear;

    //////////////////////////////////////////////////////////////////////
    // serial path
    //////////////////////////////////////////////////////////////////////

    uart_rx u_uart_rx (
        .clk                 (clk),
        .cursor_position_rst (cursor_position_rst),
        .i_rx                (i_rx),
        .o_rx_byte           (rx_byte),
        .o_rx_valid          (rx_valid)
    );

    key_decoder u_key_decoder (
        .clk                 (clk),
        .cursor_position_rst (cursor_position_rst),
        .i_rx_byte           (rx_byte),
        .i_rx_valid          (rx_valid),
        .i_tx_busy           (tx_busy),
        .o_key               (key),
        .o_key_valid         (key_valid),
        .o_echo_byte         (echo_byte),
        .o_echo_start        (echo_start)
    );

    // echo of each recognized key
    uart_tx u_uart_tx (
        .clk                 (clk),
        .cursor_position_rst (cursor_position_rst),
        .i_start             (echo_start),
        .i_byte              (echo_byte),
        .o_tx                (o_tx),
        .o_busy              (tx_busy)
    );

    //////////////////////////////////////////////////////////////////////
    // game control
    //////////////////////////////////////////////////////////////////////

    menu_cursor u_menu_cursor (
        .clk                 (clk),
        .cursor_position_rst (cursor_position_rst),
        .i_clear             (cursor_clear),
        .i_key               (key),
        .i_key_valid         (key_valid),
        .o_cursor            (o_cursor)
    );

    battle_fsm u_battle_fsm (
        .clk                 (clk),
        .cursor_position_rst (cursor_position_rst),
        .i_key               (key),
        .i_key_valid         (key_valid),
        .i_cursor            (o_cursor),
        .o_state             (o_state),
        .o_monster_hp        (o_monster_hp),
        .o_cursor_clear      (cursor_clear)
    );

endmodule

// ==== battle_chk.sv ====
`timescale 1ns/1ps

module battle_chk import battle_pkg::*; (
    input logic          clk,
    input logic          cursor_position_rst,
    input battle_state_t o_state,
    input logic [15:0]   o_monster_hp,
    input logic          o_cursor_clear
);

    int assert_errors = 0;

    hp_in_range: assert property (@(posedge clk) disable iff (cursor_position_rst)
        o_monster_hp <= MONSTER_MAX_HP)
    else begin
        assert_errors++;
        $error("monster hp %0d above the maximum", o_monster_hp);
    end

    // a strike or a refill, nothing else
    hp_steps: assert property (@(posedge clk) disable iff (cursor_position_rst)
        (o_monster_hp != $past(o_monster_hp)) |->
            (o_monster_hp == $past(o_monster_hp) - PLAYER_DAMAGE) ||
            (o_monster_hp == MONSTER_MAX_HP))
    else begin
        assert_errors++;
        $error("monster hp changed by an illegal step");
    end

    clear_pulse: assert property (@(posedge clk) disable iff (cursor_position_rst)
        o_cursor_clear |=> !o_cursor_clear)
    else begin
        assert_errors++;
        $error("cursor clear held longer than one cycle");
    end

    home_after_reset: assert property (@(posedge clk)
        $past(cursor_position_rst) |-> (o_state == ST_HOME))
    else begin
        assert_errors++;
        $error("state is not home after reset");
    end

endmodule

bind battle_fsm battle_chk u_battle_chk (
    .clk                 (clk),
    .cursor_position_rst (cursor_position_rst),
    .o_state             (o_state),
    .o_monster_hp        (o_monster_hp),
    .o_cursor_clear      (o_cursor_clear)
);

// ==== tb_battle.sv ====
`timescale 1ns/1ps

module tb_battle import battle_pkg::*; ();

    localparam int FRAME_CYCLES = 10 * CLKS_PER_BIT;
    // start edge to state update through receiver, decoder and FSM
    localparam int KEY_LATENCY  = CLKS_PER_BIT * 19 / 2 + 3;
    localparam int SETTLE       = 4;
    localparam int N_TESTS      = 6;

    typedef struct packed {
        int            test;
        logic          is_wait;
        logic [7:0]    data;
        int            cycles;
        logic          echo;
        battle_state_t state;
        menu_choice_t  cursor;
        logic [15:0]   hp;
    } row_t;

    logic          clk;
    logic          cursor_position_rst;
    logic          i_rx;
    logic          o_tx;
    battle_state_t o_state;
    menu_choice_t  o_cursor;
    logic [15:0]   o_monster_hp;

    row_t          rows [64];
    int            n_rows;
    int            errors;
    int            total_cycles;
    int            limit_cycles;
    logic [31:0]   lfsr_state;
    logic [7:0]    echo_exp [$];
    string         names [N_TESTS] = '{"reset and start", "cursor moves", "mercy and fight",
                                       "strike and monster turn", "attack timeout",
                                       "defeat after four strikes"};
    // reference model
    battle_state_t m_state;
    menu_choice_t  m_cursor;
    logic [15:0]   m_hp;
    int            m_age;

    battle_top dut (.*);

    initial begin
        clk = 1'b0;
        forever #50 clk = ~clk;
    end

    function automatic logic [31:0] lfsr_step(input logic [31:0] s);
        return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
    endfunction

    function automatic logic [7:0] take_bits(input int n);
        logic [7:0] v;
        v = '0;
        for (int i = 0; i < n; i++) begin
            lfsr_state = lfsr_step(lfsr_state);
            v = {v[6:0], lfsr_state[0]};
        end
        return v;
    endfunction

    function automatic logic is_key(input logic [7:0] b);
        return b == BYTE_ENTER || b == BYTE_SPACE || b == BYTE_A || b == BYTE_D;
    endfunction

    function automatic logic [7:0] filler_byte();
        logic [7:0] b;
        b = take_bits(8);
        while (is_key(b)) begin
            b = take_bits(8);
        end
        return b;
    endfunction

    function automatic int total_errors();
        return errors + dut.u_battle_fsm.u_battle_chk.assert_errors;
    endfunction

    //////////////////////////////////////////////////////////////////////
    // reference model
    //////////////////////////////////////////////////////////////////////

    // age counts cycles since entering a timed state
    task automatic model_advance(input int n);
        m_age += n;
        if (m_state == ST_PLAYER_ATTACK && m_age >= ATTACK_WINDOW_CYCLES) begin
            m_state = ST_MONSTER_TURN;
            m_age  -= ATTACK_WINDOW_CYCLES;
        end
        if (m_state == ST_MONSTER_TURN && m_age >= MONSTER_TURN_CYCLES) begin
            m_state  = ST_MENU;
            m_cursor = MENU_FIGHT;
            m_age   -= MONSTER_TURN_CYCLES;
        end
    endtask

    task automatic model_key(input logic [7:0] b);
        if (b == BYTE_A && m_cursor != MENU_FIGHT) begin
            m_cursor = menu_choice_t'(m_cursor - 2'd1);
        end
        if (b == BYTE_D && m_cursor != MENU_MERCY) begin
            m_cursor = menu_choice_t'(m_cursor + 2'd1);
        end
        if (b == BYTE_ENTER && m_state == ST_HOME) begin
            m_state  = ST_MENU;
            m_cursor = MENU_FIGHT;
        end else if (b == BYTE_ENTER && m_state == ST_MENU && m_cursor == MENU_FIGHT) begin
            m_state = ST_PLAYER_ATTACK;
            m_age   = 0;
        end else if (b == BYTE_ENTER && m_state == ST_MENU && m_cursor == MENU_MERCY) begin
            m_state = ST_HOME;
            m_hp    = MONSTER_MAX_HP;
        end else if (b == BYTE_SPACE && m_state == ST_PLAYER_ATTACK) begin
            m_age = 0;
            // last strike defeats the monster
            if (m_hp <= PLAYER_DAMAGE) begin
                m_state = ST_HOME;
                m_hp    = MONSTER_MAX_HP;
            end else begin
                m_state = ST_MONSTER_TURN;
                m_hp    = m_hp - PLAYER_DAMAGE;
            end
        end
    endtask

    task automatic add_row(input int test, input logic is_wait, input logic [7:0] b,
                           input int n);
        row_t r;
        if (is_wait) begin
            model_advance(n + 1);
            total_cycles += n + 1;
        end else begin
            model_advance(n + KEY_LATENCY);
            model_key(b);
            model_advance(FRAME_CYCLES - KEY_LATENCY + SETTLE + 1);
            total_cycles += n + FRAME_CYCLES + SETTLE + 1;
        end
        r.test    = test;
        r.is_wait = is_wait;
        r.data    = b;
        r.cycles  = n;
        r.echo    = !is_wait && is_key(b);
        r.state   = m_state;
        r.cursor  = m_cursor;
        r.hp      = m_hp;
        rows[n_rows] = r;
        n_rows++;
    endtask

    // random idle gap of 0 to 63 cycles ahead of each byte
    task automatic add_key(input int test, input logic [7:0] b);
        add_row(test, 1'b0, b, int'(take_bits(6)));
    endtask

    task automatic build_table();
        add_row(1, 1'b1, 8'h00, 2);
        add_key(1, BYTE_ENTER);
        repeat (4) add_key(2, BYTE_D);
        add_key(2, filler_byte());
        repeat (4) add_key(2, BYTE_A);
        add_key(2, filler_byte());
        repeat (3) add_key(2, BYTE_D);
        add_key(3, BYTE_ENTER);
        add_key(3, BYTE_ENTER);
        add_key(3, BYTE_D);
        add_key(3, BYTE_ENTER);
        add_key(3, BYTE_A);
        add_key(3, BYTE_ENTER);
        add_key(4, BYTE_SPACE);
        add_key(4, BYTE_A);
        add_key(4, BYTE_D);
        add_row(4, 1'b1, 8'h00, MONSTER_TURN_CYCLES + 200);
        add_key(5, BYTE_ENTER);
        add_row(5, 1'b1, 8'h00, ATTACK_WINDOW_CYCLES + 200);
        add_row(5, 1'b1, 8'h00, MONSTER_TURN_CYCLES);
        repeat (3) add_key(5, BYTE_D);
        add_key(5, BYTE_ENTER);
        add_key(6, BYTE_ENTER);
        for (int k = 0; k < 3; k++) begin
            add_key(6, BYTE_ENTER);
            add_key(6, BYTE_SPACE);
            add_row(6, 1'b1, 8'h00, MONSTER_TURN_CYCLES + 200);
        end
        add_key(6, BYTE_ENTER);
        add_key(6, BYTE_SPACE);
    endtask

    //////////////////////////////////////////////////////////////////////
    // serial driver, echo monitor, checks
    //////////////////////////////////////////////////////////////////////

    task automatic send_byte(input logic [7:0] b);
        logic [9:0] frame;
        frame = {1'b1, b, 1'b0};
        for (int i = 0; i < 10; i++) begin
            i_rx <= frame[i];
            repeat (CLKS_PER_BIT) @(posedge clk);
        end
    endtask

    task automatic check_value(input string what, input logic [31:0] got,
                               input logic [31:0] exp);
        if (got !== exp) begin
            errors++;
            $display("mismatch at %0t: %s is %0h, expected %0h", $time, what, got, exp);
        end
    endtask

    task automatic drain_echoes();
        int n;
        n = 0;
        while (echo_exp.size() != 0 && n < 3 * FRAME_CYCLES) begin
            @(posedge clk);
            n++;
        end
        if (echo_exp.size() != 0) begin
            errors++;
            $display("error at %0t: %0d echo bytes never came back", $time, echo_exp.size());
            echo_exp.delete();
        end
    endtask

    initial begin : echo_monitor
        logic [7:0] b;
        forever begin
            @(negedge clk);
            if (cursor_position_rst === 1'b0 && o_tx === 1'b0) begin
                // wait to mid start bit then step one bit time per sample
                repeat (CLKS_PER_BIT / 2) @(negedge clk);
                for (int i = 0; i < 8; i++) begin
                    repeat (CLKS_PER_BIT) @(negedge clk);
                    b[i] = o_tx;
                end
                repeat (CLKS_PER_BIT) @(negedge clk);
                check_value("echo stop bit", o_tx, 1'b1);
                if (echo_exp.size() == 0) begin
                    errors++;
                    $display("error at %0t: byte %0h echoed with no key sent", $time, b);
                end else begin
                    check_value("echo byte", b, echo_exp.pop_front());
                end
            end
        end
    end

    initial begin : watchdog
        wait (limit_cycles > 0);
        repeat (limit_cycles) @(posedge clk);
        $display("timeout: the run did not finish within %0d cycles", limit_cycles);
        $display("TEST RESULT: FAIL");
        $finish;
    end

    initial begin : main
        row_t r;
        int   first_err;
        int   passed;
        i_rx                = 1'b1;
        cursor_position_rst = 1'b1;
        lfsr_state          = 32'h70fbc0d0;
        m_state             = ST_HOME;
        m_cursor            = MENU_FIGHT;
        m_hp                = MONSTER_MAX_HP;
        m_age               = 0;
        passed              = 0;
        first_err           = 0;
        build_table();
        limit_cycles = 2 * total_cycles;
        repeat (10) @(posedge clk);
        cursor_position_rst <= 1'b0;
        @(negedge clk);
        check_value("idle o_tx", o_tx, 1'b1);
        @(posedge clk);
        for (int i = 0; i < n_rows; i++) begin
            r = rows[i];
            repeat (r.cycles) @(posedge clk);
            if (!r.is_wait) begin
                if (r.echo) begin
                    echo_exp.push_back(r.data);
                end
                send_byte(r.data);
                repeat (SETTLE) @(posedge clk);
            end
            @(negedge clk);
            check_value("state", o_state, r.state);
            check_value("cursor", o_cursor, r.cursor);
            check_value("monster hp", o_monster_hp, r.hp);
            @(posedge clk);
            if (i == n_rows - 1 || rows[i + 1].test != r.test) begin
                drain_echoes();
                if (total_errors() == first_err) begin
                    passed++;
                    $display("test %0d %s: ok", r.test, names[r.test - 1]);
                end else begin
                    $display("test %0d %s: %0d errors", r.test, names[r.test - 1],
                             total_errors() - first_err);
                end
                first_err = total_errors();
            end
        end
        $display("%0d tests, %0d passed, %0d failed, %0d errors", N_TESTS, passed,
                 N_TESTS - passed, total_errors());
        if (total_errors() == 0) begin
            $display("TEST RESULT: PASS");
        end else begin
            $display("TEST RESULT: FAIL");
        end
        $finish;
    end

endmodule

// ==== battle.f ====
battle_pkg.sv
uart_rx.sv
uart_tx.sv
key_decoder.sv
menu_cursor.sv
battle_fsm.sv
battle_top.sv
battle_chk.sv
tb_battle.sv
